// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= csr_tb
RTL_TOP ?= csr_top
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/pipe_slice.sv
hw/csr_access.sv
hw/csr_regfile.sv
hw/trap_ctrl.sv
hw/csr_top.sv
verification/csr_chk.sv
verification/csr_tb.sv

// ==== hw/csr_access.sv ====
`timescale 1ns/1ps

module csr_access import csr_pkg::*, trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic req_valid,
	input csr_req_t req,
	output logic req_ready,
	input logic rsp_ready,
	input logic trap_busy,
	input mode_t cur_mode,
	output logic [11:0] rd_addr,
	input logic [XLEN-1:0] rd_data,
	output logic wr_en,
	output logic [11:0] wr_addr,
	output logic [XLEN-1:0] wr_data,
	output logic rsp_valid,
	output csr_rsp_t rsp
);

	logic take;
	logic priv_ok;
	logic read_only;
	logic is_write;
	logic err;
	logic [XLEN-1:0] new_val;
	logic rsp_valid_q;
	csr_rsp_t rsp_q;

	// hold off while a trap is pending so updates never overlap
	assign req_ready = (!rsp_valid_q || rsp_ready) && !trap_busy;
	assign take = req_valid && req_ready;

	assign rd_addr = req.addr;

	assign priv_ok = req.addr[9:8] <= cur_mode;
	assign read_only = req.addr[11:10] == 2'b11;
	// set or clear with a zero mask leaves the register alone
	assign is_write = (req.op == OP_WRITE) || (req.wdata != '0);
	assign err = !priv_ok || (read_only && is_write);

	always_comb
	begin
		case (req.op)
			OP_SET: new_val = rd_data | req.wdata;
			OP_CLEAR: new_val = rd_data & ~req.wdata;
			default: new_val = req.wdata;
		endcase
	end

	assign wr_en = take && !err;
	assign wr_addr = req.addr;
	assign wr_data = new_val;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			rsp_valid_q <= 1'b0;
		else if (take)
			rsp_valid_q <= 1'b1;
		else if (rsp_ready)
			rsp_valid_q <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			rsp_q.rdata <= err ? '0 : rd_data;	// nothing leaks on refusal
			rsp_q.err <= err;
		end
	end

	assign rsp_valid = rsp_valid_q;
	assign rsp = rsp_q;

endmodule

// ==== hw/csr_pkg.sv ====
package csr_pkg;

	localparam int XLEN = 32;

	// privilege levels as in the address bits 9:8
	typedef enum logic [1:0]
	{
		MODE_U = 2'b00,
		MODE_S = 2'b01,
		MODE_M = 2'b11
	} mode_t;

	typedef logic [XLEN-2:0] cause_t;

	localparam cause_t CAUSE_INSTR_MISALIGNED = 31'd0;
	localparam cause_t CAUSE_ILLEGAL_INSTR = 31'd2;
	localparam cause_t CAUSE_ECALL_U = 31'd8;
	localparam cause_t CAUSE_ECALL_S = 31'd9;
	localparam cause_t CAUSE_ECALL_M = 31'd11;

	// machine level
	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MEDELEG = 12'h302;
	localparam logic [11:0] CSR_MIDELEG = 12'h303;
	localparam logic [11:0] CSR_MIE = 12'h304;
	localparam logic [11:0] CSR_MTVEC = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC = 12'h341;
	localparam logic [11:0] CSR_MCAUSE = 12'h342;
	localparam logic [11:0] CSR_MTVAL = 12'h343;
	localparam logic [11:0] CSR_MIP = 12'h344;
	// supervisor level
	localparam logic [11:0] CSR_STVEC = 12'h105;
	localparam logic [11:0] CSR_SEPC = 12'h141;
	localparam logic [11:0] CSR_SCAUSE = 12'h142;
	localparam logic [11:0] CSR_STVAL = 12'h143;

	localparam int MSTATUS_SIE = 1;
	localparam int MSTATUS_MIE = 3;
	localparam int MSTATUS_SPIE = 5;
	localparam int MSTATUS_MPIE = 7;
	localparam int MSTATUS_SPP = 8;
	localparam int MSTATUS_MPP = 11;	// low bit of the 2-bit field

	localparam int MIP_SEIP = 9;
	localparam int MIP_MEIP = 11;
	localparam logic [11:0] MIE_MASK = 12'haaa;	// s/m software, timer, external enables

endpackage

// ==== hw/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile import csr_pkg::*, trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic [11:0] rd_addr,
	output logic [XLEN-1:0] rd_data,
	input logic wr_en,
	input logic [11:0] wr_addr,
	input logic [XLEN-1:0] wr_data,
	input trap_upd_t upd,
	input logic ext_irq_m,
	input logic ext_irq_s,
	output csr_state_t state
);

	// mstatus fields
	logic sie, mie, spie, mpie, spp;
	mode_t mpp;

	logic [11:0] mie_q;
	logic [XLEN-1:2] mtvec, stvec, mepc, sepc;	// direct mode, word aligned
	logic [XLEN-1:0] mcause, mtval, mscratch;
	logic [XLEN-1:0] scause, stval;
	logic [15:0] medeleg;
	logic [11:0] mideleg;
	logic [XLEN-1:0] mstatus_v;
	logic [XLEN-1:0] mip_v;

	always_comb
	begin
		mstatus_v = '0;
		mstatus_v[MSTATUS_SIE] = sie;
		mstatus_v[MSTATUS_MIE] = mie;
		mstatus_v[MSTATUS_SPIE] = spie;
		mstatus_v[MSTATUS_MPIE] = mpie;
		mstatus_v[MSTATUS_SPP] = spp;
		mstatus_v[MSTATUS_MPP +: 2] = mpp;
		mip_v = '0;
		mip_v[MIP_SEIP] = ext_irq_s;	// lines only, no arbitration
		mip_v[MIP_MEIP] = ext_irq_m;
	end

	always_comb
	begin
		case (rd_addr)
			CSR_MSTATUS: rd_data = mstatus_v;
			CSR_MEDELEG: rd_data = {16'b0, medeleg};
			CSR_MIDELEG: rd_data = {20'b0, mideleg};
			CSR_MIE: rd_data = {20'b0, mie_q};
			CSR_MTVEC: rd_data = {mtvec, 2'b00};
			CSR_MSCRATCH: rd_data = mscratch;
			CSR_MEPC: rd_data = {mepc, 2'b00};
			CSR_MCAUSE: rd_data = mcause;
			CSR_MTVAL: rd_data = mtval;
			CSR_MIP: rd_data = mip_v;
			CSR_STVEC: rd_data = {stvec, 2'b00};
			CSR_SEPC: rd_data = {sepc, 2'b00};
			CSR_SCAUSE: rd_data = scause;
			CSR_STVAL: rd_data = stval;
			default: rd_data = '0;	// unimplemented and id registers
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			{sie, mie, spie, mpie, spp} <= '0;
			mpp <= MODE_M;
			mie_q <= '0;
			{mtvec, stvec, mepc, sepc} <= '0;
			{mcause, mtval, mscratch, scause, stval} <= '0;
			medeleg <= '0;
			mideleg <= '0;
		end
		else if (upd.enter_m)
		begin
			mepc <= upd.epc[XLEN-1:2];
			mcause <= {upd.interrupt, upd.code};
			mtval <= upd.tval;
			mpie <= mie;
			mie <= 1'b0;
			mpp <= upd.prev_mode;
		end
		else if (upd.enter_s)
		begin
			sepc <= upd.epc[XLEN-1:2];
			scause <= {upd.interrupt, upd.code};
			stval <= upd.tval;
			spie <= sie;
			sie <= 1'b0;
			spp <= upd.prev_mode == MODE_S;	// only U or S get delegated
		end
		else if (upd.ret_m)
		begin
			mie <= mpie;
			mpie <= 1'b1;
			mpp <= MODE_U;
		end
		else if (upd.ret_s)
		begin
			sie <= spie;
			spie <= 1'b1;
			spp <= 1'b0;
		end
		else if (wr_en)
		begin
			case (wr_addr)
				CSR_MSTATUS:
				begin
					sie <= wr_data[MSTATUS_SIE];
					mie <= wr_data[MSTATUS_MIE];
					spie <= wr_data[MSTATUS_SPIE];
					mpie <= wr_data[MSTATUS_MPIE];
					spp <= wr_data[MSTATUS_SPP];
					// 2'b10 is reserved, keep the old mode
					if (wr_data[MSTATUS_MPP +: 2] != 2'b10)
						mpp <= mode_t'(wr_data[MSTATUS_MPP +: 2]);
				end
				CSR_MEDELEG: medeleg <= wr_data[15:0];
				CSR_MIDELEG: mideleg <= wr_data[11:0];
				CSR_MIE: mie_q <= wr_data[11:0] & MIE_MASK;
				CSR_MTVEC: mtvec <= wr_data[XLEN-1:2];
				CSR_MSCRATCH: mscratch <= wr_data;
				CSR_MEPC: mepc <= wr_data[XLEN-1:2];
				CSR_MCAUSE: mcause <= wr_data;
				CSR_MTVAL: mtval <= wr_data;
				CSR_STVEC: stvec <= wr_data[XLEN-1:2];
				CSR_SEPC: sepc <= wr_data[XLEN-1:2];
				CSR_SCAUSE: scause <= wr_data;
				CSR_STVAL: stval <= wr_data;
				default: ;	// mip and read-only space ignore writes
			endcase
		end
	end

	assign state.mpp = mpp;
	assign state.spp = spp;
	assign state.medeleg = medeleg;
	assign state.mideleg = mideleg;
	assign state.mtvec = {mtvec, 2'b00};
	assign state.stvec = {stvec, 2'b00};
	assign state.mepc = {mepc, 2'b00};
	assign state.sepc = {sepc, 2'b00};

endmodule

// ==== hw/csr_top.sv ====
`timescale 1ns/1ps

module csr_top import csr_pkg::*, trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic csr_req_valid,
	input csr_req_t csr_req,
	output logic csr_req_ready,
	output logic csr_rsp_valid,
	output csr_rsp_t csr_rsp,
	input logic csr_rsp_ready,
	input logic trap_req_valid,
	input trap_req_t trap_req,
	output logic trap_req_ready,
	output logic redirect_valid,
	output redirect_t redirect,
	input logic redirect_ready,
	input logic ext_irq_m,
	input logic ext_irq_s
);

	logic csr_valid, csr_ready;
	csr_req_t csr_item;
	logic trap_valid, trap_ready;
	trap_req_t trap_item;
	logic trap_busy;
	mode_t cur_mode;
	logic [11:0] rd_addr, wr_addr;
	logic [XLEN-1:0] rd_data, wr_data;
	logic wr_en;
	trap_upd_t upd;
	csr_state_t state;

	pipe_slice #(.T(csr_req_t)) csr_slice_i (
		.clk(clk), .nrst(nrst),
		.in_valid(csr_req_valid), .in_data(csr_req), .in_ready(csr_req_ready),
		.out_valid(csr_valid), .out_data(csr_item), .out_ready(csr_ready)
	);

	pipe_slice #(.T(trap_req_t)) trap_slice_i (
		.clk(clk), .nrst(nrst),
		.in_valid(trap_req_valid), .in_data(trap_req), .in_ready(trap_req_ready),
		.out_valid(trap_valid), .out_data(trap_item), .out_ready(trap_ready)
	);

	csr_access access_i (
		.clk(clk), .nrst(nrst),
		.req_valid(csr_valid), .req(csr_item), .req_ready(csr_ready),
		.rsp_ready(csr_rsp_ready), .trap_busy(trap_busy), .cur_mode(cur_mode),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rsp_valid(csr_rsp_valid), .rsp(csr_rsp)
	);

	csr_regfile regfile_i (
		.clk(clk), .nrst(nrst),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.upd(upd), .ext_irq_m(ext_irq_m), .ext_irq_s(ext_irq_s),
		.state(state)
	);

	trap_ctrl trap_i (
		.clk(clk), .nrst(nrst),
		.trap_valid(trap_valid), .trap(trap_item), .trap_ready(trap_ready),
		.trap_busy(trap_busy), .state(state), .upd(upd), .cur_mode(cur_mode),
		.redirect_valid(redirect_valid), .redirect_ready(redirect_ready),
		.redirect(redirect)
	);

endmodule

// ==== hw/pipe_slice.sv ====
`timescale 1ns/1ps

module pipe_slice #(
	parameter type T = logic
) (
	input logic clk,
	input logic nrst,
	input logic in_valid,
	input T in_data,
	output logic in_ready,
	output logic out_valid,
	output T out_data,
	input logic out_ready
);

	logic valid_q;
	T data_q;

	// free when empty or drained this cycle
	assign in_ready = !valid_q || out_ready;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			valid_q <= 1'b0;
		else if (in_ready)
			valid_q <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			data_q <= in_data;
	end

	assign out_valid = valid_q;
	assign out_data = data_q;

endmodule

// ==== hw/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl import csr_pkg::*, trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic trap_valid,
	input trap_req_t trap,
	output logic trap_ready,
	output logic trap_busy,
	input csr_state_t state,
	output trap_upd_t upd,
	output mode_t cur_mode,
	output logic redirect_valid,
	input logic redirect_ready,
	output redirect_t redirect
);

	logic take;
	logic is_entry;
	logic is_irq;
	logic [15:0] deleg_vec;
	logic to_s;
	mode_t target;
	logic [XLEN-1:0] target_pc;
	mode_t mode_q;
	logic redir_valid_q;
	redirect_t redir_q;

	assign trap_ready = !redir_valid_q || redirect_ready;
	assign take = trap_valid && trap_ready;
	// any pending trap blocks the csr path for that cycle
	assign trap_busy = trap_valid;

	assign is_irq = trap.kind == TRAP_IRQ;
	assign is_entry = (trap.kind == TRAP_EXC) || is_irq;
	assign deleg_vec = is_irq ? {4'b0, state.mideleg} : state.medeleg;
	// M-mode traps never drop to S
	assign to_s = (mode_q != MODE_M) && (trap.code[XLEN-2:4] == '0) && deleg_vec[trap.code[3:0]];

	always_comb
	begin
		case (trap.kind)
			TRAP_MRET:
			begin
				target = state.mpp;
				target_pc = state.mepc;
			end
			TRAP_SRET:
			begin
				target = state.spp ? MODE_S : MODE_U;
				target_pc = state.sepc;
			end
			default:
			begin
				target = to_s ? MODE_S : MODE_M;
				target_pc = to_s ? state.stvec : state.mtvec;
			end
		endcase
	end

	assign upd.enter_m = take && is_entry && !to_s;
	assign upd.enter_s = take && is_entry && to_s;
	assign upd.ret_m = take && (trap.kind == TRAP_MRET);
	assign upd.ret_s = take && (trap.kind == TRAP_SRET);
	assign upd.interrupt = is_irq;
	assign upd.code = trap.code;
	assign upd.epc = trap.pc;
	assign upd.tval = trap.tval;
	assign upd.prev_mode = mode_q;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mode_q <= MODE_M;
			redir_valid_q <= 1'b0;
		end
		else if (take)
		begin
			mode_q <= target;
			redir_valid_q <= 1'b1;
		end
		else if (redirect_ready)
			redir_valid_q <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			redir_q.pc <= target_pc;
			redir_q.mode <= target;
		end
	end

	assign cur_mode = mode_q;
	assign redirect_valid = redir_valid_q;
	assign redirect = redir_q;

endmodule

// ==== hw/trap_pkg.sv ====
package trap_pkg;

	import csr_pkg::*;

	typedef enum logic [1:0]
	{
		OP_WRITE = 2'd0,
		OP_SET = 2'd1,
		OP_CLEAR = 2'd2
	} csr_op_t;

	typedef struct packed
	{
		csr_op_t op;
		logic [11:0] addr;
		logic [XLEN-1:0] wdata;
	} csr_req_t;

	typedef struct packed
	{
		logic [XLEN-1:0] rdata;
		logic err;
	} csr_rsp_t;

	typedef enum logic [1:0]
	{
		TRAP_EXC = 2'd0,
		TRAP_IRQ = 2'd1,
		TRAP_MRET = 2'd2,
		TRAP_SRET = 2'd3
	} trap_kind_t;

	typedef struct packed
	{
		trap_kind_t kind;
		cause_t code;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] tval;
	} trap_req_t;

	typedef struct packed
	{
		logic [XLEN-1:0] pc;
		mode_t mode;
	} redirect_t;

	// one-cycle strobe from trap_ctrl into the register file
	typedef struct packed
	{
		logic enter_m;
		logic enter_s;
		logic ret_m;
		logic ret_s;
		logic interrupt;
		cause_t code;
		logic [XLEN-1:0] epc;
		logic [XLEN-1:0] tval;
		mode_t prev_mode;
	} trap_upd_t;

	// register file fields the trap controller looks at
	typedef struct packed
	{
		mode_t mpp;
		logic spp;
		logic [15:0] medeleg;
		logic [11:0] mideleg;
		logic [XLEN-1:0] mtvec;
		logic [XLEN-1:0] stvec;
		logic [XLEN-1:0] mepc;
		logic [XLEN-1:0] sepc;
	} csr_state_t;

endpackage

// ==== verification/csr_chk.sv ====
`timescale 1ns/1ps

module csr_chk import csr_pkg::*, trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic csr_rsp_valid,
	input logic csr_rsp_ready,
	input csr_rsp_t csr_rsp,
	input logic redirect_valid,
	input logic redirect_ready,
	input redirect_t redirect,
	input logic csr_valid,
	input logic csr_ready,
	input csr_req_t csr_item,
	input logic wr_en,
	input trap_upd_t upd,
	input mode_t cur_mode
);

	int fails = 0;
	logic refused;

	// privilege or read-only violation of the item being taken
	assign refused = (csr_item.addr[9:8] > cur_mode) ||
		(csr_item.addr[11:10] == 2'b11 && (csr_item.op == OP_WRITE || csr_item.wdata != '0));

	rsp_hold: assert property (@(posedge clk) disable iff (!nrst)
		csr_rsp_valid && !csr_rsp_ready |=> csr_rsp_valid && $stable(csr_rsp))
	else
	begin
		fails++;
		$error("csr response dropped or changed while stalled");
	end

	redirect_hold: assert property (@(posedge clk) disable iff (!nrst)
		redirect_valid && !redirect_ready |=> redirect_valid && $stable(redirect))
	else
	begin
		fails++;
		$error("redirect dropped or changed while stalled");
	end

	quiet_in_reset: assert property (@(posedge clk) !nrst |-> !csr_rsp_valid && !redirect_valid)
	else
	begin
		fails++;
		$error("output valid raised during reset");
	end

	// entry only ever raises privilege
	entry_mode: assert property (@(posedge clk) disable iff (!nrst)
		upd.enter_m || upd.enter_s |=> redirect.mode >= $past(cur_mode))
	else
	begin
		fails++;
		$error("trap entry lowered the mode");
	end

	no_write_on_err: assert property (@(posedge clk) disable iff (!nrst)
		csr_valid && csr_ready && refused |-> !wr_en)
	else
	begin
		fails++;
		$error("refused csr access wrote the register file");
	end

endmodule

// ==== verification/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb import csr_pkg::*, trap_pkg::*; ();

	logic clk = 1'b0;
	logic nrst;
	logic csr_req_valid;
	csr_req_t csr_req;
	logic csr_req_ready;
	logic csr_rsp_valid;
	csr_rsp_t csr_rsp;
	logic csr_rsp_ready;
	logic trap_req_valid;
	trap_req_t trap_req;
	logic trap_req_ready;
	logic redirect_valid;
	redirect_t redirect;
	logic redirect_ready;
	logic ext_irq_m;
	logic ext_irq_s;

	logic [31:0] lfsr = 32'd45;
	logic [31:0] shadow [logic [11:0]];	// reference register values
	logic [33:0] csr_exp_q [$];
	logic [33:0] redir_exp_q [$];
	mode_t mode;
	logic bp_on;
	int errors = 0;
	int checks = 0;
	int issued = 0;
	int cycles = 0;
	int tests = 0;
	int mark;

	always #4 clk = ~clk;

	csr_top dut_i (.*);

	bind csr_top csr_chk chk_i (
		.clk(clk), .nrst(nrst),
		.csr_rsp_valid(csr_rsp_valid), .csr_rsp_ready(csr_rsp_ready), .csr_rsp(csr_rsp),
		.redirect_valid(redirect_valid), .redirect_ready(redirect_ready),
		.redirect(redirect), .csr_valid(csr_valid), .csr_ready(csr_ready),
		.csr_item(csr_item), .wr_en(wr_en), .upd(upd), .cur_mode(cur_mode)
	);

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] shadow_read(input logic [11:0] addr);
		return shadow.exists(addr) ? shadow[addr] : 32'h0;
	endfunction

	// warl masks of the implemented registers
	function automatic void shadow_write(input logic [11:0] addr, input logic [31:0] val);
		logic [31:0] v;
		logic [31:0] prev;
		v = val;
		prev = shadow_read(addr);
		case (addr)
			CSR_MSTATUS:
			begin
				if (v[MSTATUS_MPP +: 2] == 2'b10)
					v[MSTATUS_MPP +: 2] = prev[MSTATUS_MPP +: 2];
				shadow[addr] = v & 32'h0000_19aa;
			end
			CSR_MEDELEG: shadow[addr] = v & 32'h0000_ffff;
			CSR_MIDELEG: shadow[addr] = v & 32'h0000_0fff;
			CSR_MIE: shadow[addr] = v & 32'h0000_0aaa;
			CSR_MTVEC, CSR_STVEC, CSR_MEPC, CSR_SEPC: shadow[addr] = v & ~32'h3;
			CSR_MSCRATCH, CSR_MCAUSE, CSR_MTVAL, CSR_SCAUSE, CSR_STVAL: shadow[addr] = v;
			default: ;
		endcase
	endfunction

	task automatic csr_issue(input csr_op_t op, input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] old;
		logic [31:0] nv;
		logic err;
		csr_req_t r;
		old = shadow_read(addr);
		err = (addr[9:8] > mode) || (addr[11:10] == 2'b11 && (op == OP_WRITE || data != 0));
		case (op)
			OP_SET: nv = old | data;
			OP_CLEAR: nv = old & ~data;
			default: nv = data;
		endcase
		if (!err)
			shadow_write(addr, nv);
		csr_exp_q.push_back({1'b0, err ? 32'h0 : old, err});
		issued++;
		r.op = op;
		r.addr = addr;
		r.wdata = data;
		@(posedge clk);
		csr_req_valid <= 1'b1;
		csr_req <= r;
		@(negedge clk);
		while (!csr_req_ready)
			@(negedge clk);
		@(posedge clk);
		csr_req_valid <= 1'b0;
	endtask

	task automatic csr_read(input logic [11:0] addr);
		csr_issue(OP_SET, addr, 32'h0);	// zero mask reads without writing
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (csr_exp_q.size() != 0 || redir_exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic trap_issue(input trap_kind_t kind, input cause_t code,
		input logic [31:0] pc, input logic [31:0] tval);
		logic [31:0] st;
		logic [31:0] deleg;
		mode_t tgt;
		logic [31:0] tpc;
		trap_req_t t;
		wait_idle();
		st = shadow_read(CSR_MSTATUS);
		deleg = (kind == TRAP_IRQ) ? shadow_read(CSR_MIDELEG) : shadow_read(CSR_MEDELEG);
		case (kind)
			TRAP_MRET:
			begin
				tgt = mode_t'(st[MSTATUS_MPP +: 2]);
				tpc = shadow_read(CSR_MEPC);
				st[MSTATUS_MIE] = st[MSTATUS_MPIE];
				st[MSTATUS_MPIE] = 1'b1;
				st[MSTATUS_MPP +: 2] = MODE_U;
			end
			TRAP_SRET:
			begin
				tgt = st[MSTATUS_SPP] ? MODE_S : MODE_U;
				tpc = shadow_read(CSR_SEPC);
				st[MSTATUS_SIE] = st[MSTATUS_SPIE];
				st[MSTATUS_SPIE] = 1'b1;
				st[MSTATUS_SPP] = 1'b0;
			end
			default:
			begin
				if (mode != MODE_M && code < 16 && deleg[code[3:0]])
				begin
					tgt = MODE_S;
					tpc = shadow_read(CSR_STVEC);
					shadow[CSR_SEPC] = pc & ~32'h3;
					shadow[CSR_SCAUSE] = {kind == TRAP_IRQ, code};
					shadow[CSR_STVAL] = tval;
					st[MSTATUS_SPIE] = st[MSTATUS_SIE];
					st[MSTATUS_SIE] = 1'b0;
					st[MSTATUS_SPP] = mode == MODE_S;
				end
				else
				begin
					tgt = MODE_M;
					tpc = shadow_read(CSR_MTVEC);
					shadow[CSR_MEPC] = pc & ~32'h3;
					shadow[CSR_MCAUSE] = {kind == TRAP_IRQ, code};
					shadow[CSR_MTVAL] = tval;
					st[MSTATUS_MPIE] = st[MSTATUS_MIE];
					st[MSTATUS_MIE] = 1'b0;
					st[MSTATUS_MPP +: 2] = mode;
				end
			end
		endcase
		shadow[CSR_MSTATUS] = st;
		redir_exp_q.push_back({tpc, tgt});
		mode = tgt;
		issued++;
		t.kind = kind;
		t.code = code;
		t.pc = pc;
		t.tval = tval;
		@(posedge clk);
		trap_req_valid <= 1'b1;
		trap_req <= t;
		@(negedge clk);
		while (!trap_req_ready)
			@(negedge clk);
		@(posedge clk);
		trap_req_valid <= 1'b0;
		wait_idle();
	endtask

	task automatic rmw_sequence(input logic [11:0] addr);
		csr_issue(OP_WRITE, addr, rand_bits(32));
		csr_issue(OP_SET, addr, rand_bits(32));
		csr_issue(OP_CLEAR, addr, rand_bits(32));
		csr_read(addr);
	endtask

	task automatic random_access();
		logic [31:0] sel;
		logic [11:0] addr;
		sel = rand_bits(3);
		case (sel[2:0])
			3'd0: addr = CSR_MSCRATCH;
			3'd1: addr = CSR_MTVEC;
			3'd2: addr = CSR_MEPC;
			3'd3: addr = CSR_MTVAL;
			3'd4: addr = CSR_MCAUSE;
			3'd5: addr = CSR_MIE;
			3'd6: addr = CSR_MEDELEG;
			default: addr = CSR_STVAL;
		endcase
		sel = rand_bits(2) % 3;
		csr_issue(csr_op_t'(sel[1:0]), addr, rand_bits(32));
	endtask

	task automatic check(input string name, input logic [33:0] got, input logic [33:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report(input string name);
		tests++;
		$display("test %0d %s: %0d mismatches", tests, name, errors - mark);
		mark = errors;
	endtask

	// responses compared in arrival order
	always @(negedge clk)
	begin
		if (nrst && csr_rsp_valid && csr_rsp_ready)
		begin
			if (csr_exp_q.size() == 0)
			begin
				errors++;
				$display("csr response arrived with no request outstanding");
			end
			else
				check("csr_rsp", {1'b0, csr_rsp}, csr_exp_q.pop_front());
		end
		if (nrst && redirect_valid && redirect_ready)
		begin
			if (redir_exp_q.size() == 0)
			begin
				errors++;
				$display("redirect arrived with no trap outstanding");
			end
			else
				check("redirect", redirect, redir_exp_q.pop_front());
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > 50 * issued + 200)
		begin
			$display("timeout: no progress after %0d cycles, %0d issued", cycles, issued);
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		nrst = 1'b0;
		csr_req_valid = 1'b0;
		csr_req = '0;
		csr_rsp_ready = 1'b1;
		trap_req_valid = 1'b0;
		trap_req = '0;
		redirect_ready = 1'b1;
		ext_irq_m = 1'b0;
		ext_irq_s = 1'b0;
		bp_on = 1'b0;
		mode = MODE_M;
		mark = 0;
		shadow[CSR_MSTATUS] = 32'h0000_1800;	// mpp = M out of reset
		repeat (10) @(posedge clk);
		nrst <= 1'b1;

		csr_read(CSR_MSTATUS);
		csr_read(CSR_MTVEC);
		csr_read(CSR_MEPC);
		csr_read(CSR_MEDELEG);
		csr_read(CSR_STVEC);
		csr_read(CSR_MIP);
		csr_read(12'hf11);	// id space reads zero
		wait_idle();
		report("reset values");

		rmw_sequence(CSR_MSCRATCH);
		rmw_sequence(CSR_MTVEC);
		csr_issue(OP_WRITE, CSR_MEPC, rand_bits(32) | 32'h3);
		csr_read(CSR_MEPC);
		csr_issue(OP_WRITE, CSR_MEDELEG, 32'hffff_ffff);
		csr_read(CSR_MEDELEG);
		csr_issue(OP_WRITE, CSR_MEDELEG, 32'h0);
		csr_issue(OP_CLEAR, CSR_MSTATUS, 32'h0000_0800);	// reserved mpp is kept
		csr_read(CSR_MSTATUS);
		csr_issue(OP_WRITE, CSR_MSTATUS, 32'h0000_0800);
		csr_read(CSR_MSTATUS);
		ext_irq_m <= 1'b1;
		ext_irq_s <= 1'b1;
		shadow[CSR_MIP] = 32'h0000_0a00;	// meip and seip pending
		csr_issue(OP_WRITE, CSR_MIP, rand_bits(32));	// mip ignores writes
		csr_read(CSR_MIP);
		wait_idle();
		report("read modify write");

		csr_issue(OP_WRITE, CSR_MTVEC, rand_bits(32));
		csr_issue(OP_SET, CSR_MSTATUS, 32'h0000_0008);
		trap_issue(TRAP_EXC, CAUSE_ILLEGAL_INSTR, rand_bits(32), rand_bits(32));
		csr_read(CSR_MEPC);
		csr_read(CSR_MCAUSE);
		csr_read(CSR_MTVAL);
		csr_read(CSR_MSTATUS);
		trap_issue(TRAP_MRET, 31'd0, 32'h0, 32'h0);
		csr_read(CSR_MSTATUS);
		wait_idle();
		report("m-mode trap");

		csr_issue(OP_SET, CSR_MEDELEG, 32'h0000_0100);
		// delegable cause taken in M stays in M
		trap_issue(TRAP_EXC, CAUSE_ECALL_U, rand_bits(32), 32'h0);
		csr_issue(OP_WRITE, CSR_STVEC, rand_bits(32));
		csr_issue(OP_WRITE, CSR_MEPC, rand_bits(32));
		csr_issue(OP_CLEAR, CSR_MSTATUS, 32'h0000_1800);
		trap_issue(TRAP_MRET, 31'd0, 32'h0, 32'h0);
		trap_issue(TRAP_EXC, CAUSE_ECALL_U, rand_bits(32), 32'h0);
		csr_read(CSR_SEPC);
		csr_read(CSR_SCAUSE);
		trap_issue(TRAP_SRET, 31'd0, 32'h0, 32'h0);
		trap_issue(TRAP_EXC, CAUSE_ILLEGAL_INSTR, rand_bits(32), rand_bits(32));
		csr_read(CSR_MSTATUS);
		wait_idle();
		report("delegation");

		csr_issue(OP_WRITE, CSR_MSTATUS, 32'h0000_0800);
		trap_issue(TRAP_MRET, 31'd0, 32'h0, 32'h0);
		csr_issue(OP_WRITE, CSR_MSCRATCH, rand_bits(32));
		csr_read(CSR_MSTATUS);
		csr_issue(OP_WRITE, 12'hc00, rand_bits(32));
		csr_read(12'hc00);
		csr_issue(OP_WRITE, CSR_STVEC, rand_bits(32));
		trap_issue(TRAP_SRET, 31'd0, 32'h0, 32'h0);
		csr_issue(OP_WRITE, CSR_STVEC, rand_bits(32));
		csr_issue(OP_WRITE, CSR_MTVEC, rand_bits(32));
		trap_issue(TRAP_EXC, CAUSE_ILLEGAL_INSTR, rand_bits(32), rand_bits(32));
		csr_read(CSR_MSCRATCH);
		csr_read(CSR_STVEC);
		csr_read(CSR_MTVEC);
		wait_idle();
		report("privilege");

		bp_on = 1'b1;
		fork
			begin
				repeat (24) random_access();
				wait_idle();
				repeat (4)
				begin
					trap_issue(TRAP_EXC, CAUSE_ECALL_M, rand_bits(32), rand_bits(32));
					trap_issue(TRAP_MRET, 31'd0, 32'h0, 32'h0);
				end
				bp_on = 1'b0;
			end
			begin
				while (bp_on)
				begin
					@(posedge clk);
					csr_rsp_ready <= rand_bits(2) != 0;
					redirect_ready <= rand_bits(2) != 0;
				end
				csr_rsp_ready <= 1'b1;
				redirect_ready <= 1'b1;
			end
		join
		report("back-pressure");

		repeat (5) @(posedge clk);
		$display("%0d tests, %0d checks, %0d mismatches, %0d assertion failures",
			tests, checks, errors, dut_i.chk_i.fails);
		if (errors == 0 && dut_i.chk_i.fails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
